/* logic/dispatch_config.svh */
`ifndef DISPATCH_CONFIG_SVH
`define DISPATCH_CONFIG_SVH

// Datapath width
`define DATA_W      32

// Architectural register file
`define ARCH_REGS   32
`define ARCH_ADDR_W 5

// Reorder buffer sizing
`define ROB_DEPTH   8
`define ROB_IDX_W   3

`define LANES       2              // Dispatch lanes, also result-bus ports
`define RD_PORTS    (2 * `LANES)   // Two source operands per lane

`endif

/* logic/dispatch_pkg.sv */
`include "dispatch_config.svh"

package dispatch_pkg;

    // Opcode class seen by dispatch
    typedef enum logic [1:0] {
        OP_ALU     = 2'd0,  // rd, register B
        OP_ALU_IMM = 2'd1,  // rd, immediate B
        OP_STORE   = 2'd2,  // No rd, immediate B, rs2 as store data
        OP_BRANCH  = 2'd3   // No rd, register B
    } op_kind_e;

    typedef enum logic [1:0] {
        ROB_EMPTY   = 2'd0,
        ROB_WAITING = 2'd1,
        ROB_DONE    = 2'd2
    } rob_state_e;

    typedef struct packed {
        logic                  from_rob;  // Low selects the register file
        logic [`ROB_IDX_W-1:0] rob_idx;
    } src_ref_t;

    typedef struct packed {
        logic                    valid;
        op_kind_e                op;
        logic [`ARCH_ADDR_W-1:0] rd;
        logic [`ARCH_ADDR_W-1:0] rs1;
        logic [`ARCH_ADDR_W-1:0] rs2;
        src_ref_t                src_a;
        src_ref_t                src_b;
        logic [`DATA_W-1:0]      imm;
    } dispatch_req_t;

    // One result-bus port
    typedef struct packed {
        logic                  valid;
        logic [`ROB_IDX_W-1:0] rob_idx;
        logic [`DATA_W-1:0]    data;
    } cdb_t;

    // Registered per-lane operand bundle
    typedef struct packed {
        logic                  valid;
        op_kind_e              op;
        logic                  dest_valid;
        logic [`ROB_IDX_W-1:0] dest_tag;
        logic                  a_ready;
        logic [`ROB_IDX_W-1:0] a_tag;
        logic [`DATA_W-1:0]    a_data;
        logic                  b_ready;
        logic [`ROB_IDX_W-1:0] b_tag;
        logic [`DATA_W-1:0]    b_data;
        logic [`DATA_W-1:0]    store_data;
    } operand_t;

    typedef struct packed {
        logic                    valid;
        logic [`ARCH_ADDR_W-1:0] rd;
        logic [`DATA_W-1:0]      data;
    } commit_t;

    // Entry needed only for register writers with a real destination
    function automatic logic needs_rob(dispatch_req_t r);
        return r.valid && (r.op == OP_ALU || r.op == OP_ALU_IMM) && (r.rd != '0);
    endfunction

endpackage

/* logic/reorder_buffer.sv */
`include "dispatch_config.svh"

module reorder_buffer import dispatch_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  dispatch_req_t         req [`LANES],
    input  logic                  accept,
    input  cdb_t                  cdb [`LANES],
    input  src_ref_t              rd_src [`RD_PORTS],
    output rob_state_e            rd_state [`RD_PORTS],
    output logic [`DATA_W-1:0]    rd_data [`RD_PORTS],
    output logic [`ROB_IDX_W-1:0] alloc_idx [`LANES],
    output logic                  dispatch_ready,
    output commit_t               commit [`LANES]
);

    // ============================================================
    // Entry table and pointers
    // ============================================================

    rob_state_e              state_q [`ROB_DEPTH];
    logic [`ARCH_ADDR_W-1:0] rd_q    [`ROB_DEPTH];  // Destination per entry
    logic [`DATA_W-1:0]      data_q  [`ROB_DEPTH];  // Captured result

    logic [`ROB_IDX_W-1:0] head_q;  // Oldest entry
    logic [`ROB_IDX_W-1:0] tail_q;  // Next entry to hand out
    logic [`ROB_IDX_W:0]   free_q;  // 0..ROB_DEPTH

    logic [`LANES-1:0]     alloc_en;
    logic [`LANES-1:0]     retire;
    logic [`ROB_IDX_W-1:0] commit_idx [`LANES];
    logic [`ROB_IDX_W:0]   n_alloc;
    logic [`ROB_IDX_W:0]   n_retire;

    // Room for a full group of lanes
    assign dispatch_ready = (free_q >= `LANES);

    // ============================================================
    // Allocation, lane 0 first
    // ============================================================

    always_comb begin
        logic [`ROB_IDX_W-1:0] slot;
        slot    = tail_q;
        n_alloc = '0;
        for (int l = 0; l < `LANES; l++) begin
            alloc_en[l]  = accept && needs_rob(req[l]);
            alloc_idx[l] = slot;  // Only meaningful when alloc_en is set
            if (alloc_en[l]) begin
                slot    = slot + 1'b1;  // Next lane gets the following entry
                n_alloc = n_alloc + 1'b1;
            end
        end
    end

    // ============================================================
    // In-order retirement
    // ============================================================

    always_comb begin
        logic [`ROB_IDX_W-1:0] idx;
        logic                  older_done;
        idx        = head_q;
        older_done = 1'b1;
        n_retire   = '0;
        for (int l = 0; l < `LANES; l++) begin
            commit_idx[l]  = idx;
            retire[l]      = older_done && (state_q[idx] == ROB_DONE);
            older_done     = retire[l];  // Stop at first entry not done
            commit[l].valid = retire[l];
            commit[l].rd    = rd_q[idx];
            commit[l].data  = data_q[idx];
            if (retire[l]) begin
                n_retire = n_retire + 1'b1;
            end
            idx = idx + 1'b1;
        end
    end

    // Operand lookups see pre-edge state, no bypass
    always_comb begin
        for (int p = 0; p < `RD_PORTS; p++) begin
            rd_state[p] = state_q[rd_src[p].rob_idx];
            rd_data[p]  = data_q[rd_src[p].rob_idx];
        end
    end

    // ============================================================
    // State update
    // ============================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state_q[i] <= ROB_EMPTY;
            end
            head_q <= '0;
            tail_q <= '0;
            free_q <= (`ROB_IDX_W + 1)'(`ROB_DEPTH);  // All entries free
        end else begin
            // Retire, allocate and capture never touch the same entry
            for (int l = 0; l < `LANES; l++) begin
                if (retire[l]) begin
                    state_q[commit_idx[l]] <= ROB_EMPTY;
                end
                if (alloc_en[l]) begin
                    state_q[alloc_idx[l]] <= ROB_WAITING;
                end
                if (cdb[l].valid) begin
                    state_q[cdb[l].rob_idx] <= ROB_DONE;
                end
            end
            head_q <= head_q + n_retire[`ROB_IDX_W-1:0];
            tail_q <= tail_q + n_alloc[`ROB_IDX_W-1:0];
            free_q <= free_q + n_retire - n_alloc;
        end
    end

    // Payload columns
    always_ff @(posedge clk) begin
        for (int l = 0; l < `LANES; l++) begin
            if (alloc_en[l]) begin
                rd_q[alloc_idx[l]] <= req[l].rd;
            end
            if (cdb[l].valid) begin
                data_q[cdb[l].rob_idx] <= cdb[l].data;  // Result bus capture
            end
        end
    end

endmodule

/* logic/arch_reg_file.sv */
`include "dispatch_config.svh"

module arch_reg_file import dispatch_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`ARCH_ADDR_W-1:0] raddr [`RD_PORTS],
    output logic [`DATA_W-1:0]      rdata [`RD_PORTS],
    input  commit_t                 commit [`LANES]
);

    logic [`DATA_W-1:0] regs_q [`ARCH_REGS];

    // Commit writes; later port wins on same register
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            for (int l = 0; l < `LANES; l++) begin
                if (commit[l].valid && commit[l].rd != '0) begin  // x0 never written
                    regs_q[commit[l].rd] <= commit[l].data;
                end
            end
        end
    end

    // Combinational reads, x0 forced to zero
    always_comb begin
        for (int p = 0; p < `RD_PORTS; p++) begin
            rdata[p] = (raddr[p] == '0) ? '0 : regs_q[raddr[p]];
        end
    end

endmodule

/* logic/operand_select.sv */
`include "dispatch_config.svh"

module operand_select import dispatch_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  dispatch_req_t         req [`LANES],
    input  logic                  accept,
    input  rob_state_e            rob_state [`RD_PORTS],
    input  logic [`DATA_W-1:0]    rob_data [`RD_PORTS],
    input  logic [`DATA_W-1:0]    rf_data [`RD_PORTS],
    input  logic [`ROB_IDX_W-1:0] alloc_idx [`LANES],
    output operand_t              operands [`LANES]
);

    operand_t next [`LANES];

    // ============================================================
    // Per-lane source resolution
    // ============================================================

    always_comb begin
        logic               a_rdy;
        logic               b_rdy;
        logic               use_imm;
        logic [`DATA_W-1:0] a_val;
        logic [`DATA_W-1:0] b_val;
        for (int l = 0; l < `LANES; l++) begin
            // Port 2l is operand A (rs1), port 2l+1 is operand B (rs2)
            a_val = req[l].src_a.from_rob ? rob_data[2*l] : rf_data[2*l];
            b_val = req[l].src_b.from_rob ? rob_data[2*l+1] : rf_data[2*l+1];
            a_rdy = !req[l].src_a.from_rob || (rob_state[2*l] == ROB_DONE);
            b_rdy = !req[l].src_b.from_rob || (rob_state[2*l+1] == ROB_DONE);
            use_imm = (req[l].op == OP_ALU_IMM) || (req[l].op == OP_STORE);

            next[l].valid      = req[l].valid && accept;
            next[l].op         = req[l].op;
            next[l].dest_valid = accept && needs_rob(req[l]);
            next[l].dest_tag   = next[l].dest_valid ? alloc_idx[l] : '0;

            next[l].a_ready = a_rdy;
            next[l].a_tag   = a_rdy ? '0 : req[l].src_a.rob_idx;  // Tag only while waiting
            next[l].a_data  = a_val;

            // Immediate replaces B and is always ready
            next[l].b_ready = use_imm || b_rdy;
            next[l].b_tag   = (use_imm || b_rdy) ? '0 : req[l].src_b.rob_idx;
            next[l].b_data  = use_imm ? req[l].imm : b_val;

            next[l].store_data = b_val;  // rs2 value regardless of op
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int l = 0; l < `LANES; l++) begin
                operands[l] <= '0;
            end
        end else begin
            operands <= next;  // One cycle after acceptance
        end
    end

endmodule

/* logic/dispatch_stage.sv */
`include "dispatch_config.svh"

module dispatch_stage import dispatch_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  dispatch_req_t req [`LANES],
    input  cdb_t          cdb [`LANES],
    output logic          dispatch_ready,
    output operand_t      operands [`LANES],
    output commit_t       commit [`LANES]
);

    logic                    accept;
    logic [`LANES-1:0]       lane_valid;
    src_ref_t                rob_src   [`RD_PORTS];
    logic [`ARCH_ADDR_W-1:0] rf_addr   [`RD_PORTS];
    rob_state_e              rob_state [`RD_PORTS];
    logic [`DATA_W-1:0]      rob_data  [`RD_PORTS];
    logic [`DATA_W-1:0]      rf_data   [`RD_PORTS];
    logic [`ROB_IDX_W-1:0]   alloc_idx [`LANES];

    // Read port map, A then B per lane
    always_comb begin
        for (int l = 0; l < `LANES; l++) begin
            lane_valid[l]   = req[l].valid;
            rob_src[2*l]    = req[l].src_a;
            rob_src[2*l+1]  = req[l].src_b;
            rf_addr[2*l]    = req[l].rs1;
            rf_addr[2*l+1]  = req[l].rs2;
        end
    end

    assign accept = dispatch_ready && (|lane_valid);  // Ignored while not ready

    // ============================================================
    // ROB, register file and operand mux
    // ============================================================

    reorder_buffer u_rob (
        .clk            (clk),
        .reset          (reset),
        .req            (req),
        .accept         (accept),
        .cdb            (cdb),
        .rd_src         (rob_src),
        .rd_state       (rob_state),
        .rd_data        (rob_data),
        .alloc_idx      (alloc_idx),
        .dispatch_ready (dispatch_ready),
        .commit         (commit)
    );

    arch_reg_file u_arf (
        .clk    (clk),
        .reset  (reset),
        .raddr  (rf_addr),
        .rdata  (rf_data),
        .commit (commit)  // Same retire group the ROB frees
    );

    operand_select u_opsel (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .accept    (accept),
        .rob_state (rob_state),
        .rob_data  (rob_data),
        .rf_data   (rf_data),
        .alloc_idx (alloc_idx),
        .operands  (operands)
    );

endmodule

/* testbench/dispatch_sva.sv */
`include "dispatch_config.svh"

module dispatch_sva import dispatch_pkg::*; (
    input logic                clk,
    input logic                reset,
    input logic                dispatch_ready,
    input logic [`ROB_IDX_W:0] free_cnt,
    input commit_t             commit [`LANES]
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // Tally for the closing report

    // ============================================================
    // Reset values
    // ============================================================

    reset_values: assert property (@(posedge clk)
        $fell(reset) |-> dispatch_ready && !commit[0].valid && !commit[1].valid)
        else begin
            $error("ROB not empty in the first cycle after reset");
            fail_count++;
        end

    // ============================================================
    // Retirement and capacity
    // ============================================================

    // Only entries with a real destination ever reach retirement
    commit_dest: assert property (@(posedge clk) disable iff (reset)
        (!commit[0].valid || commit[0].rd != '0) && (!commit[1].valid || commit[1].rd != '0))
        else begin
            $error("commit retiring an entry without a destination register");
            fail_count++;
        end

    free_bound: assert property (@(posedge clk) disable iff (reset)
        free_cnt <= `ROB_DEPTH)
        else begin
            $error("free count above ROB depth");
            fail_count++;
        end

    // Below a full lane group nothing may allocate
    no_alloc_when_full: assert property (@(posedge clk) disable iff (reset)
        (free_cnt < `LANES) |=> (free_cnt >= $past(free_cnt)))
        else begin
            $error("entries allocated while dispatch was not ready");
            fail_count++;
        end

endmodule

/* testbench/dispatch_checker.sv */
`include "dispatch_config.svh"

module dispatch_checker import dispatch_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  dispatch_req_t req [`LANES],
    input  cdb_t          cdb [`LANES],
    input  logic          dispatch_ready,
    input  operand_t      operands [`LANES],
    input  commit_t       commit [`LANES],
    output int            error_count,
    output int            check_count,
    output logic          model_idle
);
    timeunit 1ns;
    timeprecision 1ps;

    // ============================================================
    // Reference state
    // ============================================================

    rob_state_e              m_state [`ROB_DEPTH];
    logic [`ARCH_ADDR_W-1:0] m_rd    [`ROB_DEPTH];
    logic [`DATA_W-1:0]      m_data  [`ROB_DEPTH];
    logic [`DATA_W-1:0]      m_regs  [`ARCH_REGS];  // Committed values
    int                      m_head;
    int                      m_tail;
    int                      m_free;
    operand_t                exp_ops [`LANES];      // Due after the next edge
    logic [`LANES-1:0]       sd_known;              // store_data has a defined source

    assign model_idle = (m_free == `ROB_DEPTH);

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("[ERROR] %s expected %h got %h", name, exp, act);
        end
    endtask

    function automatic logic [`DATA_W-1:0] reg_value(input logic [`ARCH_ADDR_W-1:0] a);
        return (a == '0) ? '0 : m_regs[a];  // x0 hard zero
    endfunction

    task automatic reset_model();
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            m_state[i] = ROB_EMPTY;
            m_rd[i]    = '0;
            m_data[i]  = '0;
        end
        for (int r = 0; r < `ARCH_REGS; r++) begin
            m_regs[r] = '0;
        end
        for (int l = 0; l < `LANES; l++) begin
            exp_ops[l] = '0;
        end
        m_head   = 0;
        m_tail   = 0;
        m_free   = `ROB_DEPTH;
        sd_known = '0;
    endtask

    // ============================================================
    // Output comparison, pre-edge values
    // ============================================================

    task automatic check_outputs();
        int   idx;
        logic older_done;
        compare_value("dispatch_ready", m_free >= `LANES, dispatch_ready);
        for (int l = 0; l < `LANES; l++) begin
            compare_value($sformatf("operands[%0d].valid", l), exp_ops[l].valid,
                          operands[l].valid);
            if (exp_ops[l].valid) begin
                compare_value($sformatf("operands[%0d].op", l), exp_ops[l].op, operands[l].op);
                compare_value($sformatf("operands[%0d].dest_valid", l),
                              exp_ops[l].dest_valid, operands[l].dest_valid);
                if (exp_ops[l].dest_valid) begin
                    compare_value($sformatf("operands[%0d].dest_tag", l),
                                  exp_ops[l].dest_tag, operands[l].dest_tag);
                end
                compare_value($sformatf("operands[%0d].a_ready", l),
                              exp_ops[l].a_ready, operands[l].a_ready);
                compare_value($sformatf("operands[%0d].a_tag", l),
                              exp_ops[l].a_tag, operands[l].a_tag);
                if (exp_ops[l].a_ready) begin
                    compare_value($sformatf("operands[%0d].a_data", l),
                                  exp_ops[l].a_data, operands[l].a_data);
                end
                compare_value($sformatf("operands[%0d].b_ready", l),
                              exp_ops[l].b_ready, operands[l].b_ready);
                compare_value($sformatf("operands[%0d].b_tag", l),
                              exp_ops[l].b_tag, operands[l].b_tag);
                if (exp_ops[l].b_ready) begin
                    compare_value($sformatf("operands[%0d].b_data", l),
                                  exp_ops[l].b_data, operands[l].b_data);
                end
                if (sd_known[l]) begin
                    compare_value($sformatf("operands[%0d].store_data", l),
                                  exp_ops[l].store_data, operands[l].store_data);
                end
            end
        end
        older_done = 1'b1;
        for (int l = 0; l < `LANES; l++) begin
            idx        = (m_head + l) % `ROB_DEPTH;
            older_done = older_done && (m_state[idx] == ROB_DONE);  // In-order only
            compare_value($sformatf("commit[%0d].valid", l), older_done, commit[l].valid);
            if (older_done) begin
                compare_value($sformatf("commit[%0d].rd", l), m_rd[idx], commit[l].rd);
                compare_value($sformatf("commit[%0d].data", l), m_data[idx], commit[l].data);
            end
        end
    endtask

    // ============================================================
    // Prediction and model update
    // ============================================================

    task automatic predict_operands();
        logic               accepted;
        logic               writes_rd;
        logic               imm_b;
        logic               a_ok;
        logic               b_ok;
        logic [`DATA_W-1:0] a_val;
        logic [`DATA_W-1:0] b_val;
        int                 slot;
        slot = m_tail;
        for (int l = 0; l < `LANES; l++) begin
            accepted  = req[l].valid && (m_free >= `LANES);
            writes_rd = accepted && (req[l].op == OP_ALU || req[l].op == OP_ALU_IMM)
                        && (req[l].rd != '0);
            imm_b = (req[l].op == OP_ALU_IMM) || (req[l].op == OP_STORE);
            a_ok  = !req[l].src_a.from_rob || (m_state[req[l].src_a.rob_idx] == ROB_DONE);
            b_ok  = !req[l].src_b.from_rob || (m_state[req[l].src_b.rob_idx] == ROB_DONE);
            a_val = req[l].src_a.from_rob ? m_data[req[l].src_a.rob_idx] : reg_value(req[l].rs1);
            b_val = req[l].src_b.from_rob ? m_data[req[l].src_b.rob_idx] : reg_value(req[l].rs2);

            exp_ops[l]            = '0;
            exp_ops[l].valid      = accepted;
            exp_ops[l].op         = req[l].op;
            exp_ops[l].dest_valid = writes_rd;
            exp_ops[l].dest_tag   = `ROB_IDX_W'(slot);
            if (writes_rd) begin
                slot = (slot + 1) % `ROB_DEPTH;  // Lane 1 gets the next entry
            end
            exp_ops[l].a_ready    = a_ok;
            exp_ops[l].a_tag      = a_ok ? '0 : req[l].src_a.rob_idx;
            exp_ops[l].a_data     = a_val;
            exp_ops[l].b_ready    = imm_b || b_ok;
            exp_ops[l].b_tag      = (imm_b || b_ok) ? '0 : req[l].src_b.rob_idx;
            exp_ops[l].b_data     = imm_b ? req[l].imm : b_val;
            exp_ops[l].store_data = b_val;
            sd_known[l]           = b_ok;
        end
    endtask

    task automatic advance_model();
        int   idx;
        int   n_ret;
        int   n_alloc;
        logic older_done;
        older_done = 1'b1;
        n_ret      = 0;
        for (int l = 0; l < `LANES; l++) begin
            idx = (m_head + l) % `ROB_DEPTH;
            if (older_done && m_state[idx] == ROB_DONE) begin
                m_regs[m_rd[idx]] = m_data[idx];  // Port 1 after port 0
                m_state[idx]      = ROB_EMPTY;
                n_ret++;
            end else begin
                older_done = 1'b0;
            end
        end
        n_alloc = 0;
        for (int l = 0; l < `LANES; l++) begin
            if (exp_ops[l].dest_valid) begin
                idx          = (m_tail + n_alloc) % `ROB_DEPTH;
                m_state[idx] = ROB_WAITING;
                m_rd[idx]    = req[l].rd;
                n_alloc++;
            end
        end
        for (int l = 0; l < `LANES; l++) begin
            if (cdb[l].valid) begin
                m_state[cdb[l].rob_idx] = ROB_DONE;
                m_data[cdb[l].rob_idx]  = cdb[l].data;
            end
        end
        m_head = (m_head + n_ret) % `ROB_DEPTH;
        m_tail = (m_tail + n_alloc) % `ROB_DEPTH;
        m_free = m_free + n_ret - n_alloc;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            reset_model();
        end else begin
            check_outputs();
            predict_operands();  // Uses this cycle's request and pre-edge state
            advance_model();
        end
    end

endmodule

/* testbench/dispatch_tb.sv */
`include "dispatch_config.svh"

module dispatch_tb import dispatch_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES   = 16;
    localparam int STIM_CYCLES    = 2000;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + STIM_CYCLES / 2;  // Room for reset and drain

    logic          clk;
    logic          reset;
    dispatch_req_t req [`LANES];
    cdb_t          cdb [`LANES];
    logic          dispatch_ready;
    operand_t      operands [`LANES];
    commit_t       commit [`LANES];

    int                    error_count;
    int                    check_count;
    int                    sva_failures;
    int                    cycles;
    logic                  model_idle;
    logic [31:0]           rng_state = 32'd86868;
    logic [`ROB_IDX_W-1:0] next_tag;      // Mirror of the ROB tail
    logic [`ROB_IDX_W-1:0] waiting [$];   // Allocated, result not yet sent

    dispatch_stage DUT (
        .clk            (clk),
        .reset          (reset),
        .req            (req),
        .cdb            (cdb),
        .dispatch_ready (dispatch_ready),
        .operands       (operands),
        .commit         (commit)
    );

    bind reorder_buffer dispatch_sva u_sva (
        .clk            (clk),
        .reset          (reset),
        .dispatch_ready (dispatch_ready),
        .free_cnt       (free_q),
        .commit         (commit)
    );

    dispatch_checker u_check (
        .clk            (clk),
        .reset          (reset),
        .req            (req),
        .cdb            (cdb),
        .dispatch_ready (dispatch_ready),
        .operands       (operands),
        .commit         (commit),
        .error_count    (error_count),
        .check_count    (check_count),
        .model_idle     (model_idle)
    );

    // ============================================================
    // Stimulus helpers
    // ============================================================

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {rng_state[15:0], rng_state[31:16]};  // Weak low bits moved up
    endfunction

    // Track entries the ROB hands out this edge
    task automatic note_allocations();
        for (int l = 0; l < `LANES; l++) begin
            if (dispatch_ready && req[l].valid && req[l].rd != '0
                    && (req[l].op == OP_ALU || req[l].op == OP_ALU_IMM)) begin
                waiting.push_back(next_tag);
                next_tag = next_tag + 1'b1;
            end
        end
    endtask

    task automatic drive_results(input logic drain);
        logic [31:0] r;
        int          pick;
        cdb_t        c;
        for (int p = 0; p < `LANES; p++) begin
            r = next_random();
            c = '0;
            if (waiting.size() != 0 && (drain || r[2:0] < 3'd3)) begin
                pick      = int'(r[15:8]) % waiting.size();  // Out-of-order completion
                c.valid   = 1'b1;
                c.rob_idx = waiting[pick];
                c.data    = next_random();
                waiting.delete(pick);
            end
            cdb[p] <= c;
        end
    endtask

    task automatic drive_requests(input logic active);
        logic [31:0]   r;
        dispatch_req_t q;
        for (int l = 0; l < `LANES; l++) begin
            r                = next_random();
            q.valid          = active && (r[1:0] != 2'b00);
            q.op             = op_kind_e'(r[3:2]);
            q.rd             = r[8:4];
            q.rs1            = r[13:9];
            q.rs2            = r[18:14];
            q.src_a.from_rob = r[19];
            q.src_a.rob_idx  = r[22:20];  // Any entry, waiting or not
            q.src_b.from_rob = r[23];
            q.src_b.rob_idx  = r[26:24];
            q.imm            = next_random();
            req[l] <= q;
        end
    endtask

    // ============================================================
    // Clock, timeout and main sequence
    // ============================================================

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        reset    = 1'b1;
        next_tag = '0;
        for (int l = 0; l < `LANES; l++) begin
            req[l] = '0;
            cdb[l] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        for (int c = 0; c < STIM_CYCLES; c++) begin
            @(posedge clk);
            note_allocations();
            drive_results(1'b0);
            drive_requests(1'b1);
        end

        // Drain with no new requests
        do begin
            @(posedge clk);
            note_allocations();
            drive_results(1'b1);
            drive_requests(1'b0);
        end while (waiting.size() != 0);
        @(posedge clk);
        for (int l = 0; l < `LANES; l++) begin
            cdb[l] <= '0;
        end
        while (!model_idle) @(negedge clk);
        @(posedge clk);
        @(negedge clk);

        sva_failures = DUT.u_rob.u_sva.fail_count;
        $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
                 check_count, error_count, sva_failures);
        if (error_count == 0 && sva_failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+logic
logic/dispatch_pkg.sv
logic/reorder_buffer.sv
logic/arch_reg_file.sv
logic/operand_select.sv
logic/dispatch_stage.sv
testbench/dispatch_sva.sv
testbench/dispatch_checker.sv
testbench/dispatch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the dispatch stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
FAIL_MSG='*** TEST FAILED ***'

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module dispatch_tb -f verilog.f -o sim_dispatch > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/sim_dispatch +verilator+error+limit+1000 > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "$FAIL_MSG" "$SIM_LOG"; then
    echo "Failure reported, see $SIM_LOG"
    exit 1
fi
echo "Simulation passed"
exit 0
